// File: source/stream_pkg.sv
//////////////////////////////////////////////////////////////////////
// stream beat and FIFO definitions
//////////////////////////////////////////////////////////////////////

`default_nettype none

package stream_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes

    localparam int DATA_BYTES = 4;
    localparam int FIFO_DEPTH = 16;
    // entries still free when full is raised, covers the registered flag
    localparam int GUARD_BAND = 2;
    localparam int DEPTH_LOG  = $clog2(FIFO_DEPTH);

    //////////////////////////////////////////////////////////////////////
    // types

    typedef logic [DATA_BYTES*8-1:0] tdata_t;
    typedef logic [DATA_BYTES-1:0]   tkeep_t;

    // counts 0 to FIFO_DEPTH, output register included
    typedef logic [DEPTH_LOG:0] level_t;

    // one stored RAM word
    typedef struct packed {
        tdata_t data;
        tkeep_t keep;
        logic   last;
    } beat_t;

    // single-cycle pulses, one cycle after the causing transfer
    typedef struct packed {
        logic accepted;
        logic delivered;
        logic dropped;
        logic packet_flagged;
    } fifo_events_t;

endpackage

`default_nettype wire

// File: source/csr_pkg.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite register port definitions
//////////////////////////////////////////////////////////////////////

`default_nettype none

package csr_pkg;

    typedef logic [7:0]  addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [31:0] count_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_t;

    // manager side
    typedef struct packed {
        logic  awvalid;
        addr_t awaddr;
        logic  wvalid;
        word_t wdata;
        strb_t wstrb;
        logic  bready;
        logic  arvalid;
        addr_t araddr;
        logic  rready;
    } axil_req_t;

    // subordinate side
    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        resp_t bresp;
        logic  arready;
        logic  rvalid;
        word_t rdata;
        resp_t rresp;
    } axil_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // register map

    localparam addr_t ADDR_CTRL      = 8'h00;
    localparam addr_t ADDR_LEVEL     = 8'h04;
    localparam addr_t ADDR_ACCEPTED  = 8'h08;
    localparam addr_t ADDR_DELIVERED = 8'h0C;
    localparam addr_t ADDR_DROPPED   = 8'h10;
    localparam addr_t ADDR_FLAGGED   = 8'h14;

    // CTRL bit positions
    localparam int CTRL_BACKPRESSURE = 0;
    localparam int CTRL_CLEAR        = 1;

    typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

endpackage

`default_nettype wire

// File: source/stream_word_fifo.sv
//////////////////////////////////////////////////////////////////////
// distributed RAM word FIFO
//////////////////////////////////////////////////////////////////////

`default_nettype none

module stream_word_fifo #(
    parameter int DEPTH = stream_pkg::FIFO_DEPTH
) (
    input  wire logic                 axis_out,
    input  wire logic                 rst_n,

    input  wire stream_pkg::beat_t    in_beat,
    input  wire logic                 in_valid,
    output logic                      in_ready,

    output stream_pkg::beat_t         out_beat,
    output logic                      out_valid,
    input  wire logic                 out_ready,

    input  wire logic                 allow_backpressure,
    output stream_pkg::level_t        level,
    output stream_pkg::fifo_events_t  events
);

    //////////////////////////////////////////////////////////////////////
    // constants and signals

    localparam int PTR_W = $clog2(DEPTH);

    // extra msb marks the wrap, so wr_ptr - rd_ptr is the exact count
    typedef logic [PTR_W:0] ptr_t;

    localparam ptr_t FULL_AT = ptr_t'(DEPTH - stream_pkg::GUARD_BAND);

    stream_pkg::beat_t ram [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    ptr_t occupancy;
    logic full;
    logic empty;
    logic accept;
    logic wr_en;
    logic reg_ce;
    logic deliver;
    logic pkt_drop;

    //////////////////////////////////////////////////////////////////////
    // input side

    // drop mode never stalls the source
    assign in_ready  = !full || !allow_backpressure;
    assign accept    = in_valid && in_ready;
    assign wr_en     = accept && !full;

    assign occupancy = wr_ptr - rd_ptr;
    assign empty     = (wr_ptr == rd_ptr);

    always_ff @(posedge axis_out) begin
        if (wr_en) begin
            ram[wr_ptr[PTR_W-1:0]] <= in_beat;
        end
    end

    always_ff @(posedge axis_out) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            full     <= 1'b0;
            pkt_drop <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // lags occupancy by a cycle, the guard band absorbs that
            full <= (occupancy >= FULL_AT);
            // remember a loss until the packet ends
            if (accept) begin
                if (in_beat.last) begin
                    pkt_drop <= 1'b0;
                end else if (full) begin
                    pkt_drop <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output register

    assign deliver = out_valid && out_ready;
    assign reg_ce  = (!out_valid || out_ready) && !empty;

    always_ff @(posedge axis_out) begin
        if (reg_ce) begin
            out_beat <= ram[rd_ptr[PTR_W-1:0]];
        end
    end

    always_ff @(posedge axis_out) begin
        if (!rst_n) begin
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (reg_ce) begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // RAM entries plus the beat waiting in the output register
    assign level = stream_pkg::level_t'(occupancy) + stream_pkg::level_t'(out_valid);

    //////////////////////////////////////////////////////////////////////
    // event pulses

    always_ff @(posedge axis_out) begin
        if (!rst_n) begin
            events <= '0;
        end else begin
            events.accepted       <= accept;
            events.delivered      <= deliver;
            events.dropped        <= accept && full;
            // a dropped last beat also counts as a loss in its packet
            events.packet_flagged <= accept && in_beat.last && (pkt_drop || full);
        end
    end

endmodule

`default_nettype wire

// File: source/stream_event_counters.sv
//////////////////////////////////////////////////////////////////////
// FIFO event counters
//////////////////////////////////////////////////////////////////////

`default_nettype none

module stream_event_counters (
    input  wire logic                     axis_out,
    input  wire logic                     rst_n,

    input  wire stream_pkg::fifo_events_t events,
    input  wire logic                     clear,

    output csr_pkg::count_t               accepted,
    output csr_pkg::count_t               delivered,
    output csr_pkg::count_t               dropped,
    output csr_pkg::count_t               flagged
);

    // holds at all ones instead of wrapping
    function automatic csr_pkg::count_t bump(
        input csr_pkg::count_t cnt,
        input logic            inc
    );
        csr_pkg::count_t result;
        result = cnt;
        if (inc && (cnt != '1)) begin
            result = cnt + 1'b1;
        end
        return result;
    endfunction

    always_ff @(posedge axis_out) begin
        if (!rst_n) begin
            accepted  <= '0;
            delivered <= '0;
            dropped   <= '0;
            flagged   <= '0;
        end else if (clear) begin
            // clear beats an increment in the same cycle
            accepted  <= '0;
            delivered <= '0;
            dropped   <= '0;
            flagged   <= '0;
        end else begin
            accepted  <= bump(accepted, events.accepted);
            delivered <= bump(delivered, events.delivered);
            dropped   <= bump(dropped, events.dropped);
            flagged   <= bump(flagged, events.packet_flagged);
        end
    end

endmodule

`default_nettype wire

// File: source/csr_axil_slave.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite control and status registers
//////////////////////////////////////////////////////////////////////

`default_nettype none

module csr_axil_slave (
    input  wire logic               axis_out,
    input  wire logic               rst_n,

    input  wire csr_pkg::axil_req_t req,
    output csr_pkg::axil_rsp_t      rsp,

    input  wire stream_pkg::level_t level,
    input  wire csr_pkg::count_t    accepted,
    input  wire csr_pkg::count_t    delivered,
    input  wire csr_pkg::count_t    dropped,
    input  wire csr_pkg::count_t    flagged,

    output logic                    allow_backpressure,
    output logic                    counter_clear
);

    csr_pkg::wr_state_t wr_state;
    csr_pkg::rd_state_t rd_state;

    logic            aw_done;
    logic            w_done;
    csr_pkg::addr_t  aw_addr_q;
    csr_pkg::word_t  w_data_q;
    csr_pkg::strb_t  w_strb_q;
    csr_pkg::resp_t  bresp_q;
    csr_pkg::word_t  rdata_q;
    csr_pkg::resp_t  rresp_q;

    logic            aw_ready;
    logic            w_ready;
    logic            ar_ready;
    logic            aw_hs;
    logic            w_hs;
    logic            ar_hs;
    logic            wr_fire;
    csr_pkg::addr_t  wr_addr;
    csr_pkg::word_t  wr_data;
    csr_pkg::strb_t  wr_strb;
    csr_pkg::word_t  rd_word;
    csr_pkg::resp_t  rd_resp;

    //////////////////////////////////////////////////////////////////////
    // write channel

    // AW and W are taken in either order, each only once
    assign aw_ready = (wr_state == csr_pkg::WR_IDLE) && !aw_done;
    assign w_ready  = (wr_state == csr_pkg::WR_IDLE) && !w_done;
    assign aw_hs    = req.awvalid && aw_ready;
    assign w_hs     = req.wvalid && w_ready;
    assign wr_fire  = (wr_state == csr_pkg::WR_IDLE) && (aw_done || aw_hs) && (w_done || w_hs);

    // the late channel is used straight from the bus
    assign wr_addr  = aw_done ? aw_addr_q : req.awaddr;
    assign wr_data  = w_done ? w_data_q : req.wdata;
    assign wr_strb  = w_done ? w_strb_q : req.wstrb;

    always_ff @(posedge axis_out) begin
        if (aw_hs) begin
            aw_addr_q <= req.awaddr;
        end
        if (w_hs) begin
            w_data_q <= req.wdata;
            w_strb_q <= req.wstrb;
        end
    end

    always_ff @(posedge axis_out) begin
        if (!rst_n) begin
            wr_state           <= csr_pkg::WR_IDLE;
            aw_done            <= 1'b0;
            w_done             <= 1'b0;
            bresp_q            <= csr_pkg::OKAY;
            allow_backpressure <= 1'b1;
            counter_clear      <= 1'b0;
        end else begin
            counter_clear <= 1'b0;
            case (wr_state)
                csr_pkg::WR_IDLE: begin
                    if (wr_fire) begin
                        aw_done  <= 1'b0;
                        w_done   <= 1'b0;
                        wr_state <= csr_pkg::WR_RESP;
                        // only CTRL is writable
                        if (wr_addr == csr_pkg::ADDR_CTRL) begin
                            bresp_q <= csr_pkg::OKAY;
                            if (wr_strb[0]) begin
                                allow_backpressure <= wr_data[csr_pkg::CTRL_BACKPRESSURE];
                                counter_clear      <= wr_data[csr_pkg::CTRL_CLEAR];
                            end
                        end else begin
                            bresp_q <= csr_pkg::SLVERR;
                        end
                    end else begin
                        if (aw_hs) begin
                            aw_done <= 1'b1;
                        end
                        if (w_hs) begin
                            w_done <= 1'b1;
                        end
                    end
                end
                csr_pkg::WR_RESP: begin
                    if (req.bready) begin
                        wr_state <= csr_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= csr_pkg::WR_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read channel

    assign ar_ready = (rd_state == csr_pkg::RD_IDLE);
    assign ar_hs    = req.arvalid && ar_ready;

    always_comb begin
        rd_resp = csr_pkg::OKAY;
        case (req.araddr)
            // clear bit is a pulse and reads as zero
            csr_pkg::ADDR_CTRL:      rd_word = csr_pkg::word_t'(allow_backpressure);
            csr_pkg::ADDR_LEVEL:     rd_word = csr_pkg::word_t'(level);
            csr_pkg::ADDR_ACCEPTED:  rd_word = accepted;
            csr_pkg::ADDR_DELIVERED: rd_word = delivered;
            csr_pkg::ADDR_DROPPED:   rd_word = dropped;
            csr_pkg::ADDR_FLAGGED:   rd_word = flagged;
            default: begin
                rd_word = '0;
                rd_resp = csr_pkg::SLVERR;
            end
        endcase
    end

    always_ff @(posedge axis_out) begin
        if (ar_hs) begin
            rdata_q <= rd_word;
        end
    end

    always_ff @(posedge axis_out) begin
        if (!rst_n) begin
            rd_state <= csr_pkg::RD_IDLE;
            rresp_q  <= csr_pkg::OKAY;
        end else begin
            case (rd_state)
                csr_pkg::RD_IDLE: begin
                    if (ar_hs) begin
                        rresp_q  <= rd_resp;
                        rd_state <= csr_pkg::RD_RESP;
                    end
                end
                csr_pkg::RD_RESP: begin
                    if (req.rready) begin
                        rd_state <= csr_pkg::RD_IDLE;
                    end
                end
                default: rd_state <= csr_pkg::RD_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response bundle

    always_comb begin
        rsp.awready = aw_ready;
        rsp.wready  = w_ready;
        rsp.bvalid  = (wr_state == csr_pkg::WR_RESP);
        rsp.bresp   = bresp_q;
        rsp.arready = ar_ready;
        rsp.rvalid  = (rd_state == csr_pkg::RD_RESP);
        rsp.rdata   = rdata_q;
        rsp.rresp   = rresp_q;
    end

endmodule

`default_nettype wire

// File: source/stream_fifo_top.sv
//////////////////////////////////////////////////////////////////////
// packet stream buffer top level
//////////////////////////////////////////////////////////////////////

`default_nettype none

module stream_fifo_top (
    input  wire logic               axis_out,
    input  wire logic               rst_n,

    input  wire stream_pkg::beat_t  in_beat,
    input  wire logic               in_valid,
    output logic                    in_ready,

    output stream_pkg::beat_t       out_beat,
    output logic                    out_valid,
    input  wire logic               out_ready,

    input  wire csr_pkg::axil_req_t axil_req,
    output csr_pkg::axil_rsp_t      axil_rsp
);

    stream_pkg::level_t       level;
    stream_pkg::fifo_events_t events;
    logic                     allow_backpressure;
    logic                     counter_clear;
    csr_pkg::count_t          accepted;
    csr_pkg::count_t          delivered;
    csr_pkg::count_t          dropped;
    csr_pkg::count_t          flagged;

    stream_word_fifo #(
        .DEPTH              (stream_pkg::FIFO_DEPTH)
    ) u_fifo (
        .axis_out           (axis_out),
        .rst_n              (rst_n),
        .in_beat            (in_beat),
        .in_valid           (in_valid),
        .in_ready           (in_ready),
        .out_beat           (out_beat),
        .out_valid          (out_valid),
        .out_ready          (out_ready),
        .allow_backpressure (allow_backpressure),
        .level              (level),
        .events             (events)
    );

    stream_event_counters u_counters (
        .axis_out  (axis_out),
        .rst_n     (rst_n),
        .events    (events),
        .clear     (counter_clear),
        .accepted  (accepted),
        .delivered (delivered),
        .dropped   (dropped),
        .flagged   (flagged)
    );

    csr_axil_slave u_csr (
        .axis_out           (axis_out),
        .rst_n              (rst_n),
        .req                (axil_req),
        .rsp                (axil_rsp),
        .level              (level),
        .accepted           (accepted),
        .delivered          (delivered),
        .dropped            (dropped),
        .flagged            (flagged),
        .allow_backpressure (allow_backpressure),
        .counter_clear      (counter_clear)
    );

endmodule

`default_nettype wire

// File: test/tb_stream_fifo_tasks.svh
//////////////////////////////////////////////////////////////////////
// testbench reference model and bus tasks
//////////////////////////////////////////////////////////////////////

`ifndef TB_STREAM_FIFO_TASKS_SVH
`define TB_STREAM_FIFO_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// typed compares

task automatic check_beat(input string name, input stream_pkg::beat_t exp,
                          input stream_pkg::beat_t act);
    if (act !== exp) begin
        $display("error %s: expected %h, actual %h", name, exp, act);
        value_errors++;
    end
endtask

task automatic check_word(input string name, input csr_pkg::word_t exp,
                          input csr_pkg::word_t act);
    if (act !== exp) begin
        $display("error %s: expected %h, actual %h", name, exp, act);
        value_errors++;
    end
endtask

task automatic check_resp(input string name, input csr_pkg::resp_t exp,
                          input csr_pkg::resp_t act);
    if (act !== exp) begin
        $display("error %s: expected %h, actual %h", name, exp, act);
        value_errors++;
    end
endtask

//////////////////////////////////////////////////////////////////////
// drop mode reference

// walks sent beats against delivered ones, returns 0 if order broke
function automatic bit drop_reference(output int missing, output int flagged_pkts);
    int j;
    bit lost;
    j = 0;
    lost = 1'b0;
    missing = 0;
    flagged_pkts = 0;
    foreach (sent_q[i]) begin
        if (j < seen_q.size() && seen_q[j] == sent_q[i]) begin
            j++;
        end else begin
            missing++;
            lost = 1'b1;
        end
        // a lost last beat still closes its packet
        if (sent_q[i].last) begin
            if (lost) begin
                flagged_pkts++;
            end
            lost = 1'b0;
        end
    end
    return j == seen_q.size();
endfunction

//////////////////////////////////////////////////////////////////////
// AXI4-Lite manager

task automatic read_reg(input csr_pkg::addr_t addr, output csr_pkg::word_t data,
                        output csr_pkg::resp_t resp);
    int waited;
    waited = 0;
    data = '0;
    resp = csr_pkg::SLVERR;
    @(negedge axis_out);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = 1'b1;
    @(posedge axis_out);
    while (!axil_rsp.arready && waited < TIMEOUT_CYCLES) begin
        @(posedge axis_out);
        waited++;
    end
    @(negedge axis_out);
    axil_req.arvalid = 1'b0;
    waited = 0;
    @(posedge axis_out);
    while (!axil_rsp.rvalid && waited < TIMEOUT_CYCLES) begin
        @(posedge axis_out);
        waited++;
    end
    if (axil_rsp.rvalid) begin
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
    end else begin
        $display("timeout waiting for read data from address %h", addr);
        other_failures++;
    end
    @(negedge axis_out);
    axil_req.rready = 1'b0;
endtask

task automatic write_reg(input csr_pkg::addr_t addr, input csr_pkg::word_t data,
                         output csr_pkg::resp_t resp);
    bit aw_sent;
    bit w_sent;
    int waited;
    aw_sent = 1'b0;
    w_sent  = 1'b0;
    waited  = 0;
    resp    = csr_pkg::SLVERR;
    @(negedge axis_out);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hF;
    axil_req.bready  = 1'b1;
    // address and data may be taken on different edges
    while (!(aw_sent && w_sent) && waited < TIMEOUT_CYCLES) begin
        @(posedge axis_out);
        aw_sent = aw_sent || axil_rsp.awready;
        w_sent  = w_sent || axil_rsp.wready;
        @(negedge axis_out);
        axil_req.awvalid = !aw_sent;
        axil_req.wvalid  = !w_sent;
        waited++;
    end
    waited = 0;
    @(posedge axis_out);
    while (!axil_rsp.bvalid && waited < TIMEOUT_CYCLES) begin
        @(posedge axis_out);
        waited++;
    end
    if (axil_rsp.bvalid) begin
        resp = axil_rsp.bresp;
    end else begin
        $display("timeout waiting for the write response at address %h", addr);
        other_failures++;
    end
    @(negedge axis_out);
    axil_req.bready = 1'b0;
endtask

task automatic expect_reg(input string name, input csr_pkg::addr_t addr,
                          input csr_pkg::word_t exp);
    csr_pkg::word_t data;
    csr_pkg::resp_t resp;
    read_reg(addr, data, resp);
    check_resp(name, csr_pkg::OKAY, resp);
    check_word(name, exp, data);
endtask

`endif

// File: test/tb_stream_fifo_top.sv
//////////////////////////////////////////////////////////////////////
// packet stream buffer testbench
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_stream_fifo_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int LEVEL_BEATS    = 5;

    logic               axis_out;
    logic               rst_n;
    stream_pkg::beat_t  in_beat;
    logic               in_valid;
    logic               in_ready;
    stream_pkg::beat_t  out_beat;
    logic               out_valid;
    logic               out_ready;
    csr_pkg::axil_req_t axil_req;
    csr_pkg::axil_rsp_t axil_rsp;

    // expected order in lossless mode, sent and seen beats in drop mode
    stream_pkg::beat_t exp_q[$];
    stream_pkg::beat_t sent_q[$];
    stream_pkg::beat_t seen_q[$];

    int          value_errors;
    int          other_failures;
    int          lossless_beats;
    int unsigned seq;
    bit          drop_phase;

    `include "tb_stream_fifo_tasks.svh"

    stream_fifo_top dut0 (
        .axis_out  (axis_out),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp)
    );

    always #10 axis_out = ~axis_out;

    //////////////////////////////////////////////////////////////////////
    // stream stimulus

    task automatic send_beat(input stream_pkg::beat_t beat);
        int waited;
        waited = 0;
        @(negedge axis_out);
        in_beat  = beat;
        in_valid = 1'b1;
        @(posedge axis_out);
        if (drop_phase && !in_ready) begin
            $display("in_ready went low while drop mode was on");
            other_failures++;
        end
        while (!in_ready && waited < TIMEOUT_CYCLES) begin
            @(posedge axis_out);
            waited++;
        end
        if (!in_ready) begin
            $display("timeout waiting for in_ready");
            other_failures++;
        end else if (drop_phase) begin
            sent_q.push_back(beat);
        end else begin
            exp_q.push_back(beat);
            lossless_beats++;
        end
    endtask

    task automatic send_packet(input int len, input int gap);
        stream_pkg::beat_t beat;
        int i;
        for (i = 0; i < len; i++) begin
            // sequence number keeps every beat unique
            beat.data = {seq[15:0], 16'($urandom)};
            beat.keep = stream_pkg::tkeep_t'($urandom);
            beat.last = (i == len - 1);
            seq++;
            send_beat(beat);
        end
        @(negedge axis_out);
        in_valid = 1'b0;
        repeat (gap) @(negedge axis_out);
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(posedge axis_out);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout with %0d beats still expected at the output", exp_q.size());
            other_failures++;
        end
        @(negedge axis_out);
    endtask

    // with out_ready high, a low out_valid means the FIFO ran empty
    task automatic wait_output_idle();
        int waited;
        waited = 0;
        @(posedge axis_out);
        while (out_valid && waited < TIMEOUT_CYCLES) begin
            @(posedge axis_out);
            waited++;
        end
        if (out_valid) begin
            $display("timeout waiting for the output to go idle");
            other_failures++;
        end
        @(negedge axis_out);
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare process

    always @(posedge axis_out) begin
        if (rst_n && out_valid && out_ready) begin
            if (drop_phase) begin
                seen_q.push_back(out_beat);
            end else if (exp_q.size() == 0) begin
                $display("a beat came out while none was expected");
                other_failures++;
            end else begin
                check_beat("fifo_order", exp_q.pop_front(), out_beat);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        csr_pkg::resp_t resp;
        csr_pkg::word_t data;
        int             missing;
        int             flagged_pkts;
        int             p;
        bit             stim_done;

        void'($urandom(4020));
        axis_out  = 1'b0;
        rst_n     = 1'b0;
        in_beat   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        axil_req  = '0;
        stim_done = 1'b0;
        repeat (5) @(posedge axis_out);
        @(negedge axis_out);
        rst_n = 1'b1;

        // reset values
        expect_reg("reset_ctrl", csr_pkg::ADDR_CTRL, 32'd1);
        expect_reg("reset_level", csr_pkg::ADDR_LEVEL, 32'd0);
        expect_reg("reset_accepted", csr_pkg::ADDR_ACCEPTED, 32'd0);
        expect_reg("reset_delivered", csr_pkg::ADDR_DELIVERED, 32'd0);
        expect_reg("reset_dropped", csr_pkg::ADDR_DROPPED, 32'd0);
        expect_reg("reset_flagged", csr_pkg::ADDR_FLAGGED, 32'd0);

        // lossless transfer with random output stalls
        fork
            begin
                for (p = 0; p < 20; p++) begin
                    send_packet(1 + int'($urandom % 6), int'($urandom % 3));
                end
                stim_done = 1'b1;
            end
            begin
                while (!stim_done) begin
                    @(negedge axis_out);
                    out_ready = ($urandom % 2) != 0;
                end
            end
        join
        out_ready = 1'b1;
        wait_for_drain();

        // level with the output stalled
        out_ready = 1'b0;
        send_packet(LEVEL_BEATS, 0);
        expect_reg("level_stalled", csr_pkg::ADDR_LEVEL, csr_pkg::word_t'(LEVEL_BEATS));
        out_ready = 1'b1;
        wait_for_drain();
        expect_reg("level_drained", csr_pkg::ADDR_LEVEL, 32'd0);
        expect_reg("lossless_accepted", csr_pkg::ADDR_ACCEPTED,
                   csr_pkg::word_t'(lossless_beats));
        expect_reg("lossless_delivered", csr_pkg::ADDR_DELIVERED,
                   csr_pkg::word_t'(lossless_beats));
        expect_reg("lossless_dropped", csr_pkg::ADDR_DROPPED, 32'd0);
        expect_reg("lossless_flagged", csr_pkg::ADDR_FLAGGED, 32'd0);

        // counter clear keeps backpressure on
        write_reg(csr_pkg::ADDR_CTRL, 32'h3, resp);
        check_resp("clear_write", csr_pkg::OKAY, resp);
        expect_reg("clear_ctrl", csr_pkg::ADDR_CTRL, 32'd1);
        expect_reg("clear_accepted", csr_pkg::ADDR_ACCEPTED, 32'd0);
        expect_reg("clear_delivered", csr_pkg::ADDR_DELIVERED, 32'd0);

        // drop mode burst into a stalled output
        write_reg(csr_pkg::ADDR_CTRL, 32'h0, resp);
        check_resp("drop_enable", csr_pkg::OKAY, resp);
        expect_reg("drop_ctrl", csr_pkg::ADDR_CTRL, 32'd0);
        drop_phase = 1'b1;
        out_ready  = 1'b0;
        while (sent_q.size() < 2 * stream_pkg::FIFO_DEPTH) begin
            send_packet(2 + int'($urandom % 4), 0);
        end
        out_ready = 1'b1;
        wait_output_idle();
        drop_phase = 1'b0;
        if (!drop_reference(missing, flagged_pkts)) begin
            $display("delivered beats are not an in-order subsequence of the sent beats");
            other_failures++;
        end
        if (missing == 0) begin
            $display("the drop mode burst did not lose any beat");
            other_failures++;
        end
        expect_reg("drop_accepted", csr_pkg::ADDR_ACCEPTED, csr_pkg::word_t'(sent_q.size()));
        expect_reg("drop_delivered", csr_pkg::ADDR_DELIVERED, csr_pkg::word_t'(seen_q.size()));
        expect_reg("drop_dropped", csr_pkg::ADDR_DROPPED, csr_pkg::word_t'(missing));
        expect_reg("drop_flagged", csr_pkg::ADDR_FLAGGED, csr_pkg::word_t'(flagged_pkts));

        // error responses leave every register alone
        write_reg(8'h20, 32'h3, resp);
        check_resp("unmapped_write", csr_pkg::SLVERR, resp);
        read_reg(8'h20, data, resp);
        check_resp("unmapped_read", csr_pkg::SLVERR, resp);
        write_reg(csr_pkg::ADDR_LEVEL, 32'h3, resp);
        check_resp("level_write", csr_pkg::SLVERR, resp);
        expect_reg("ctrl_after_errors", csr_pkg::ADDR_CTRL, 32'd0);
        expect_reg("level_after_errors", csr_pkg::ADDR_LEVEL, 32'd0);
        expect_reg("accepted_after_errors", csr_pkg::ADDR_ACCEPTED,
                   csr_pkg::word_t'(sent_q.size()));

        // clear with drop mode still selected
        write_reg(csr_pkg::ADDR_CTRL, 32'h2, resp);
        check_resp("drop_clear_write", csr_pkg::OKAY, resp);
        expect_reg("drop_clear_ctrl", csr_pkg::ADDR_CTRL, 32'd0);
        expect_reg("drop_clear_accepted", csr_pkg::ADDR_ACCEPTED, 32'd0);
        expect_reg("drop_clear_delivered", csr_pkg::ADDR_DELIVERED, 32'd0);
        expect_reg("drop_clear_dropped", csr_pkg::ADDR_DROPPED, 32'd0);
        expect_reg("drop_clear_flagged", csr_pkg::ADDR_FLAGGED, 32'd0);

        $display("summary: %0d value errors, %0d other failures", value_errors, other_failures);
        if (value_errors == 0 && other_failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+test
source/stream_pkg.sv
source/csr_pkg.sv
source/stream_word_fifo.sv
source/stream_event_counters.sv
source/csr_axil_slave.sv
source/stream_fifo_top.sv
test/tb_stream_fifo_top.sv

// File: Bender.yml
package:
  name: stream_fifo_buffer

sources:
  - source/stream_pkg.sv
  - source/csr_pkg.sv
  - source/stream_word_fifo.sv
  - source/stream_event_counters.sv
  - source/csr_axil_slave.sv
  - source/stream_fifo_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_stream_fifo_top.sv
